//--- src/lsu_pkg.sv
/*
 * LSU shared definitions
 * Widths, SRAM sizing, load type codes, and the packed request
 * and AXI4-Lite channel payloads used across the memory stage.
 */
package lsu_pkg;

  localparam int XLEN       = 32;
  localparam int STRB_W     = XLEN / 8;
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_WAIT  = 2;       // ready hold-off after a valid is seen

  // load types use the funct3 encoding
  localparam logic [2:0] LD_B  = 3'd0;
  localparam logic [2:0] LD_H  = 3'd1;
  localparam logic [2:0] LD_W  = 3'd2;
  localparam logic [2:0] LD_BU = 3'd4;
  localparam logic [2:0] LD_HU = 3'd5;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  typedef struct packed {
    logic              ren;
    logic              wen;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wmask;
    logic [2:0]        read_t;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    axi_resp_t       resp;
  } axi_r_t;

endpackage

//--- src/lsu_load_format.sv
/*
 * Load result formatter
 * Moves the addressed byte of the returned word down to bit 0,
 * then sign or zero extends a byte or halfword per the load type.
 */
`timescale 1ns/1ps

module lsu_load_format (
  input  logic [1:0]               i_offset,
  input  logic [2:0]               i_read_t,
  input  logic [lsu_pkg::XLEN-1:0] i_word,
  output logic [lsu_pkg::XLEN-1:0] o_rdata
);

  logic [lsu_pkg::XLEN-1:0] shifted;

  assign shifted = i_word >> {i_offset, 3'b000};  // zeros fill the top

  always_comb begin
    case (i_read_t)
      lsu_pkg::LD_B: begin
        o_rdata = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::LD_H: begin
        o_rdata = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::LD_W: begin
        o_rdata = shifted;
      end
      lsu_pkg::LD_BU: begin
        o_rdata = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      end
      lsu_pkg::LD_HU: begin
        o_rdata = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      end
      default: begin
        o_rdata = shifted;  // unknown code passes through
      end
    endcase
  end

endmodule

//--- src/lsu_store_align.sv
/*
 * Store lane alignment
 * Rotates store data left by the byte offset and moves the byte
 * mask into the same lanes. Mask bits pushed past lane 3 are lost.
 */
`timescale 1ns/1ps

module lsu_store_align (
  input  logic [1:0]                 i_offset,
  input  logic [lsu_pkg::XLEN-1:0]   i_wdata,
  input  logic [lsu_pkg::STRB_W-1:0] i_wmask,
  output lsu_pkg::axi_w_t            o_w
);

  always_comb begin
    case (i_offset)
      2'd0: begin
        o_w.data = i_wdata;
      end
      2'd1: begin
        o_w.data = {i_wdata[23:0], i_wdata[31:24]};
      end
      2'd2: begin
        o_w.data = {i_wdata[15:0], i_wdata[31:16]};
      end
      default: begin
        o_w.data = {i_wdata[7:0], i_wdata[31:8]};
      end
    endcase
    o_w.strb = i_wmask << i_offset;  // overflow lanes drop off
  end

endmodule

//--- src/lsu.sv
/*
 * Load/store unit
 * Takes one request per i_valid strobe while idle, issues it as an
 * AXI4-Lite read or write, and pulses o_valid when it completes.
 * Requests with no memory access complete on the next cycle.
 */
`timescale 1ns/1ps

module lsu (
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_valid,
  input  lsu_pkg::lsu_req_t        i_req,
  output logic                     o_valid,
  output logic [lsu_pkg::XLEN-1:0] o_rdata,
  output logic                     o_arvalid,
  output logic [lsu_pkg::XLEN-1:0] o_araddr,
  input  logic                     i_arready,
  input  logic                     i_rvalid,
  input  lsu_pkg::axi_r_t          i_r,
  output logic                     o_rready,
  output logic                     o_awvalid,
  output logic [lsu_pkg::XLEN-1:0] o_awaddr,
  input  logic                     i_awready,
  output logic                     o_wvalid,
  output lsu_pkg::axi_w_t          o_w,
  input  logic                     i_wready,
  input  logic                     i_bvalid,
  input  lsu_pkg::axi_resp_t       i_bresp,
  output logic                     o_bready
);

  lsu_pkg::lsu_req_t        req_q;
  logic                     busy;
  logic                     accept;
  logic                     done;
  logic [lsu_pkg::XLEN-1:0] load_data;
  logic [lsu_pkg::XLEN-1:0] rdata_q;

  assign accept = i_valid && !busy;  // strobes while busy are dropped
  assign done   = busy && ((req_q.ren && i_rvalid) || (req_q.wen && i_bvalid));

  always_ff @(posedge i_clock) begin
    if (accept) begin
      req_q <= i_req;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      busy    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (accept && (i_req.ren || i_req.wen)) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      o_valid <= done || (accept && !i_req.ren && !i_req.wen);
    end
  end

  // a request with both enables runs as a load
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_arvalid <= 1'b0;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
    end else begin
      if (accept && i_req.ren) begin
        o_arvalid <= 1'b1;
      end else if (o_arvalid && i_arready) begin
        o_arvalid <= 1'b0;
      end

      if (accept && i_req.wen && !i_req.ren) begin
        o_awvalid <= 1'b1;
      end else if (o_awvalid && i_awready) begin
        o_awvalid <= 1'b0;
      end

      if (accept && i_req.wen && !i_req.ren) begin
        o_wvalid <= 1'b1;
      end else if (o_wvalid && i_wready) begin
        o_wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (done) begin
      if (req_q.ren) begin
        rdata_q <= (i_r.resp == lsu_pkg::RESP_OKAY) ? load_data : '0;
      end else begin
        rdata_q <= {{(lsu_pkg::XLEN-2){1'b0}}, i_bresp};  // store returns its status
      end
    end
  end

  assign o_rdata  = rdata_q;
  assign o_araddr = req_q.addr;
  assign o_awaddr = req_q.addr;
  assign o_rready = 1'b1;
  assign o_bready = 1'b1;

  lsu_store_align u_store_align (
    .i_offset (req_q.addr[1:0]),
    .i_wdata  (req_q.wdata),
    .i_wmask  (req_q.wmask),
    .o_w      (o_w)
  );

  lsu_load_format u_load_format (
    .i_offset (req_q.addr[1:0]),
    .i_read_t (req_q.read_t),
    .i_word   (i_r.data),
    .o_rdata  (load_data)
  );

endmodule

//--- src/axi_sram.sv
/*
 * AXI4-Lite SRAM slave
 * Word-addressed on-chip memory with byte strobes. Each channel
 * waits a fixed number of cycles before raising its ready, and
 * each response holds until the master takes it.
 */
`timescale 1ns/1ps

module axi_sram (
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_arvalid,
  input  logic [lsu_pkg::XLEN-1:0] i_araddr,
  output logic                     o_arready,
  output logic                     o_rvalid,
  output lsu_pkg::axi_r_t          o_r,
  input  logic                     i_rready,
  input  logic                     i_awvalid,
  input  logic [lsu_pkg::XLEN-1:0] i_awaddr,
  output logic                     o_awready,
  input  logic                     i_wvalid,
  input  lsu_pkg::axi_w_t          i_w,
  output logic                     o_wready,
  output logic                     o_bvalid,
  output lsu_pkg::axi_resp_t       o_bresp,
  input  logic                     i_bready
);

  typedef logic [$clog2(lsu_pkg::SRAM_WAIT+1)-1:0] wait_cnt_t;
  typedef logic [$clog2(lsu_pkg::SRAM_WORDS)-1:0] word_idx_t;

  logic [lsu_pkg::XLEN-1:0] mem [lsu_pkg::SRAM_WORDS];
  logic [lsu_pkg::XLEN-1:0] rdata_q;
  wait_cnt_t                ar_cnt;
  wait_cnt_t                wr_cnt;
  logic                     wr_ready;
  word_idx_t                ar_idx;
  word_idx_t                aw_idx;
  logic                     ar_hs;
  logic                     wr_hs;

  assign ar_idx = i_araddr[$clog2(lsu_pkg::SRAM_WORDS)+1:2];  // upper bits ignored
  assign aw_idx = i_awaddr[$clog2(lsu_pkg::SRAM_WORDS)+1:2];
  assign ar_hs  = i_arvalid && o_arready;
  assign wr_hs  = i_awvalid && o_awready && i_wvalid && o_wready;

  // read address wait and response
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_arready <= 1'b0;
      ar_cnt    <= '0;
      o_rvalid  <= 1'b0;
    end else if (ar_hs) begin
      o_arready <= 1'b0;
      ar_cnt    <= '0;
      o_rvalid  <= 1'b1;
    end else begin
      if (i_arvalid && !o_arready && !o_rvalid) begin
        if (ar_cnt == wait_cnt_t'(lsu_pkg::SRAM_WAIT - 1)) begin
          o_arready <= 1'b1;
        end else begin
          ar_cnt <= ar_cnt + 1'b1;
        end
      end
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // AW and W are taken in the same cycle
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      wr_ready <= 1'b0;
      wr_cnt   <= '0;
      o_bvalid <= 1'b0;
    end else if (wr_hs) begin
      wr_ready <= 1'b0;
      wr_cnt   <= '0;
      o_bvalid <= 1'b1;
    end else begin
      if (i_awvalid && i_wvalid && !wr_ready && !o_bvalid) begin
        if (wr_cnt == wait_cnt_t'(lsu_pkg::SRAM_WAIT - 1)) begin
          wr_ready <= 1'b1;
        end else begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (wr_hs) begin
      for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
        if (i_w.strb[b]) begin
          mem[aw_idx][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
    if (ar_hs) begin
      rdata_q <= mem[ar_idx];
    end
  end

  assign o_awready = wr_ready;
  assign o_wready  = wr_ready;
  assign o_r.data  = rdata_q;
  assign o_r.resp  = lsu_pkg::RESP_OKAY;
  assign o_bresp   = lsu_pkg::RESP_OKAY;

endmodule

//--- src/lsu_top.sv
/*
 * Memory stage top
 * LSU wired to its AXI4-Lite SRAM slave.
 */
`timescale 1ns/1ps

module lsu_top (
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_valid,
  input  lsu_pkg::lsu_req_t        i_req,
  output logic                     o_valid,
  output logic [lsu_pkg::XLEN-1:0] o_rdata
);

  logic                     arvalid;
  logic [lsu_pkg::XLEN-1:0] araddr;
  logic                     arready;
  logic                     rvalid;
  lsu_pkg::axi_r_t          r;
  logic                     rready;
  logic                     awvalid;
  logic [lsu_pkg::XLEN-1:0] awaddr;
  logic                     awready;
  logic                     wvalid;
  lsu_pkg::axi_w_t          w;
  logic                     wready;
  logic                     bvalid;
  lsu_pkg::axi_resp_t       bresp;
  logic                     bready;

  lsu u_lsu (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_valid   (i_valid),
    .i_req     (i_req),
    .o_valid   (o_valid),
    .o_rdata   (o_rdata),
    .o_arvalid (arvalid),
    .o_araddr  (araddr),
    .i_arready (arready),
    .i_rvalid  (rvalid),
    .i_r       (r),
    .o_rready  (rready),
    .o_awvalid (awvalid),
    .o_awaddr  (awaddr),
    .i_awready (awready),
    .o_wvalid  (wvalid),
    .o_w       (w),
    .i_wready  (wready),
    .i_bvalid  (bvalid),
    .i_bresp   (bresp),
    .o_bready  (bready)
  );

  axi_sram u_sram (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_arvalid (arvalid),
    .i_araddr  (araddr),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_r       (r),
    .i_rready  (rready),
    .i_awvalid (awvalid),
    .i_awaddr  (awaddr),
    .o_awready (awready),
    .i_wvalid  (wvalid),
    .i_w       (w),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_bresp   (bresp),
    .i_bready  (bready)
  );

endmodule

//--- dv/tb_lsu.sv
/*
 * Testbench for the memory stage top
 * Reads access vectors, strobes each request into the LSU, waits
 * for the completion pulse and checks load results. A watchdog
 * bounds the run by the vector count.
 */
`timescale 1ns/1ps

module tb_lsu;

  localparam int MAX_VEC      = 64;
  localparam int FIELDS       = 6;   // op, addr, wdata, wmask, read_t, expected
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 3;
  localparam logic [31:0] OP_LOAD  = 32'h1;
  localparam logic [31:0] OP_STORE = 32'h2;
  localparam logic [31:0] OP_END   = 32'hf;

  logic                     clock = 1'b0;
  logic                     reset;
  logic                     valid;
  lsu_pkg::lsu_req_t        req;
  logic                     dut_valid;
  logic [lsu_pkg::XLEN-1:0] dut_rdata;
  logic [31:0]              vec_mem [MAX_VEC*FIELDS];
  int                       num_vec;
  int                       wd_cycles;

  always #2 clock = ~clock;

  lsu_top UUT (
    .i_clock (clock),
    .i_reset (reset),
    .i_valid (valid),
    .i_req   (req),
    .o_valid (dut_valid),
    .o_rdata (dut_rdata)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic lsu_pkg::lsu_req_t make_req(input int k);
    lsu_pkg::lsu_req_t r;
    logic [31:0]       op;
    op       = vec_mem[FIELDS*k];
    r.ren    = (op == OP_LOAD);
    r.wen    = (op == OP_STORE);  // op 0 leaves both low
    r.addr   = vec_mem[FIELDS*k+1];
    r.wdata  = vec_mem[FIELDS*k+2];
    r.wmask  = vec_mem[FIELDS*k+3][3:0];
    r.read_t = vec_mem[FIELDS*k+4][2:0];
    return r;
  endfunction

  // starts just after a rising edge and returns one cycle after o_valid
  task automatic run_vector(input int k);
    logic [31:0] op;
    op = vec_mem[FIELDS*k];
    check_value("o_valid", {31'b0, dut_valid}, 32'h0);  // last pulse was one cycle
    req   = make_req(k);
    valid = 1'b1;
    @(posedge clock);
    #0.5;
    valid = 1'b0;
    req   = '0;  // LSU must work from its capture register
    while (dut_valid !== 1'b1) begin
      @(posedge clock);
      #0.5;
    end
    if (op == OP_LOAD) begin
      check_value("o_rdata", dut_rdata, vec_mem[FIELDS*k+5]);
    end
    @(posedge clock);
    #0.5;
  endtask

  initial begin
    reset = 1'b1;
    valid = 1'b0;
    req   = '0;
    for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
      vec_mem[i] = OP_END;
    end
    $readmemh("dv/lsu_vectors.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[FIELDS*num_vec] != OP_END) begin
      num_vec++;
    end
    wd_cycles = num_vec * (2*lsu_pkg::SRAM_WAIT + 8) + RESET_CYCLES + IDLE_CYCLES + 2;
    if (num_vec == 0) begin
      $display("no access vectors were read from dv/lsu_vectors.txt");
      $display(">>> FAIL");
      $fatal(1, "empty vector file");
    end

    repeat (RESET_CYCLES) begin
      @(posedge clock);
      #0.5;
      check_value("o_valid", {31'b0, dut_valid}, 32'h0);
    end
    reset = 1'b0;
    repeat (IDLE_CYCLES) begin  // quiet until the first strobe
      @(posedge clock);
      #0.5;
      check_value("o_valid", {31'b0, dut_valid}, 32'h0);
    end

    for (int k = 0; k < num_vec; k++) begin
      run_vector(k);
    end

    $display("%0d accesses completed", num_vec);
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    #1;  // vector count is known by now
    repeat (wd_cycles) @(posedge clock);
    $display("timeout: o_valid never came within %0d cycles", wd_cycles);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- dv/lsu_vectors.txt
// op (0 none, 1 load, 2 store), addr, wdata, wmask, read_t, expected load data
// read_t: 0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU; a line with op f ends the list
2 00000100 12345678 f 2 00000000
1 00000100 00000000 0 2 12345678
2 00000101 000000aa 1 2 00000000
1 00000100 00000000 0 2 1234aa78
2 00000102 0000beef 3 2 00000000
1 00000100 00000000 0 2 beefaa78
2 00000103 00000011 1 2 00000000
1 00000100 00000000 0 2 11efaa78
2 00000103 00002233 3 2 00000000
1 00000100 00000000 0 2 33efaa78
2 00000100 00000080 1 2 00000000
1 00000100 00000000 0 2 33efaa80
1 00000100 00000000 0 0 ffffff80
1 00000101 00000000 0 0 ffffffaa
1 00000102 00000000 0 0 ffffffef
1 00000103 00000000 0 0 00000033
1 00000100 00000000 0 4 00000080
1 00000101 00000000 0 4 000000aa
1 00000102 00000000 0 4 000000ef
1 00000103 00000000 0 4 00000033
1 00000100 00000000 0 1 ffffaa80
1 00000101 00000000 0 1 ffffefaa
1 00000102 00000000 0 1 000033ef
1 00000103 00000000 0 1 00000033
1 00000100 00000000 0 5 0000aa80
1 00000101 00000000 0 5 0000efaa
1 00000102 00000000 0 5 000033ef
1 00000103 00000000 0 5 00000033
1 00000102 00000000 0 2 000033ef
1 00000101 00000000 0 3 0033efaa
2 00000200 7f01fe80 f 2 00000000
1 00000200 00000000 0 2 7f01fe80
1 00000200 00000000 0 1 fffffe80
1 00000202 00000000 0 1 00007f01
1 00000201 00000000 0 0 fffffffe
1 00000203 00000000 0 0 0000007f
0 00000200 deadbeef f 2 00000000
1 00000200 00000000 0 2 7f01fe80
2 00000200 12345555 3 2 00000000
1 00000200 00000000 0 2 7f015555
1 00001200 00000000 0 2 7f015555
f 00000000 00000000 0 0 00000000

//--- sources.f
src/lsu_pkg.sv
src/lsu_load_format.sv
src/lsu_store_align.sv
src/lsu.sv
src/axi_sram.sv
src/lsu_top.sv
dv/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Build the LSU testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f --top-module tb_lsu \
  -Mdir obj_dir -o tb_lsu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_lsu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
